/* hdl/pcs_capture_pkg.sv */
package pcs_capture_pkg;

    // coded block geometry
    localparam int LEN_CODED_BLOCK   = 66;
    localparam int LEN_SYNC          = 2;
    localparam int LEN_BLOCK_TYPE    = 8;
    localparam int LEN_KIND          = 4;

    // capture window
    localparam int CAPTURE_ADDR_BITS = 5;
    localparam int CAPTURE_DEPTH     = 2 ** CAPTURE_ADDR_BITS;    // blocks per window

    typedef logic [LEN_CODED_BLOCK-1:0]   coded_block_t;    // [65:64] sync, [63:56] type
    typedef logic [LEN_SYNC-1:0]          sync_hdr_t;
    typedef logic [LEN_BLOCK_TYPE-1:0]    block_type_t;
    typedef logic [CAPTURE_ADDR_BITS-1:0] capture_addr_t;

    // legal sync headers
    localparam sync_hdr_t SYNC_DATA = 2'b01;
    localparam sync_hdr_t SYNC_CTRL = 2'b10;

    // block-type byte of control blocks
    localparam block_type_t BT_IDLE        = 8'h1e;
    localparam block_type_t BT_START_0     = 8'h78;
    localparam block_type_t BT_START_4     = 8'h33;
    localparam block_type_t BT_OS_START    = 8'h66;
    localparam block_type_t BT_ORDERED_SET = 8'h4b;
    localparam block_type_t BT_TERM_0      = 8'h87;
    localparam block_type_t BT_TERM_1      = 8'h99;
    localparam block_type_t BT_TERM_2      = 8'haa;
    localparam block_type_t BT_TERM_3      = 8'hb4;
    localparam block_type_t BT_TERM_4      = 8'hcc;
    localparam block_type_t BT_TERM_5      = 8'hd2;
    localparam block_type_t BT_TERM_6      = 8'he1;
    localparam block_type_t BT_TERM_7      = 8'hff;

    typedef enum logic [LEN_KIND-1:0] {
        KIND_DATA    = 4'd0,
        KIND_IDLE    = 4'd1,
        KIND_START   = 4'd2,     // S0, S4 and ordered-set start
        KIND_ORDERED = 4'd3,
        KIND_TERM    = 4'd4,     // any of T0..T7
        KIND_ERROR   = 4'd15     // bad sync or unknown type byte
    } block_kind_e;

    // block as stored in the capture memories
    typedef struct packed {
        coded_block_t block;
        block_kind_e  kind;
    } decoded_block_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_FULL
    } capture_state_e;

endpackage

/* hdl/block_kind_decoder.sv */
`timescale 1ns/10ps

module block_kind_decoder
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_valid,
    input  pcs_capture_pkg::coded_block_t   i_block,
    output logic                            o_valid,
    output pcs_capture_pkg::decoded_block_t o_dec
);

    pcs_capture_pkg::sync_hdr_t   sync_hdr;
    pcs_capture_pkg::block_type_t type_byte;
    pcs_capture_pkg::block_kind_e kind;

    // true for the eight terminate types
    function automatic logic is_term(input pcs_capture_pkg::block_type_t bt);
        logic hit;
        case (bt)
            pcs_capture_pkg::BT_TERM_0,
            pcs_capture_pkg::BT_TERM_1,
            pcs_capture_pkg::BT_TERM_2,
            pcs_capture_pkg::BT_TERM_3,
            pcs_capture_pkg::BT_TERM_4,
            pcs_capture_pkg::BT_TERM_5,
            pcs_capture_pkg::BT_TERM_6,
            pcs_capture_pkg::BT_TERM_7:
                hit = 1'b1;
            default:
                hit = 1'b0;
        endcase
        return hit;
    endfunction

    // kind of a block that carries a control sync
    function automatic pcs_capture_pkg::block_kind_e ctrl_kind(
        input pcs_capture_pkg::block_type_t bt
    );
        pcs_capture_pkg::block_kind_e k;
        case (bt)
            pcs_capture_pkg::BT_IDLE:
                k = pcs_capture_pkg::KIND_IDLE;
            pcs_capture_pkg::BT_START_0,
            pcs_capture_pkg::BT_START_4,
            pcs_capture_pkg::BT_OS_START:
                k = pcs_capture_pkg::KIND_START;
            pcs_capture_pkg::BT_ORDERED_SET:
                k = pcs_capture_pkg::KIND_ORDERED;
            default:
            begin
                if (is_term(bt))
                    k = pcs_capture_pkg::KIND_TERM;
                else
                    k = pcs_capture_pkg::KIND_ERROR;    // unlisted type byte
            end
        endcase
        return k;
    endfunction

    assign sync_hdr  = i_block[pcs_capture_pkg::LEN_CODED_BLOCK-1 -: pcs_capture_pkg::LEN_SYNC];
    assign type_byte = i_block[pcs_capture_pkg::LEN_CODED_BLOCK-pcs_capture_pkg::LEN_SYNC-1
                               -: pcs_capture_pkg::LEN_BLOCK_TYPE];

    always_comb
    begin
        case (sync_hdr)
            pcs_capture_pkg::SYNC_DATA:
                kind = pcs_capture_pkg::KIND_DATA;     // payload is not inspected
            pcs_capture_pkg::SYNC_CTRL:
                kind = ctrl_kind(type_byte);
            default:
                kind = pcs_capture_pkg::KIND_ERROR;    // 00 or 11
        endcase
    end

    // one-cycle strobe, aligned with the registered block
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    // block and kind only move on a strobe
    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_dec.block <= i_block;
            o_dec.kind  <= kind;
        end
    end

endmodule

/* hdl/capture_bram.sv */
`timescale 1ns/10ps

module capture_bram
#(
    parameter int NB_WORD = 66
)
(
    input  logic                           i_clock,
    input  logic                           i_write_enable,
    input  pcs_capture_pkg::capture_addr_t i_write_addr,
    input  logic [NB_WORD-1:0]             i_data,
    input  logic                           i_read_enable,
    input  pcs_capture_pkg::capture_addr_t i_read_addr,
    output logic [NB_WORD-1:0]             o_data
);

    logic [NB_WORD-1:0] mem [pcs_capture_pkg::CAPTURE_DEPTH];

    always_ff @(posedge i_clock)
    begin
        if (i_write_enable)
            mem[i_write_addr] <= i_data;
    end

    // registered read, holds last word between strobes
    always_ff @(posedge i_clock)
    begin
        if (i_read_enable)
            o_data <= mem[i_read_addr];
    end

endmodule

/* hdl/capture_control.sv */
`timescale 1ns/10ps

module capture_control
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_run,
    input  logic                            i_dec_valid,
    input  pcs_capture_pkg::decoded_block_t i_dec,
    input  logic                            i_read_strobe,
    input  pcs_capture_pkg::capture_addr_t  i_read_addr,
    output logic                            o_full,
    output logic                            o_read_valid,
    output pcs_capture_pkg::coded_block_t   o_read_block,
    output pcs_capture_pkg::block_kind_e    o_read_kind
);

    pcs_capture_pkg::capture_state_e state;
    pcs_capture_pkg::capture_state_e state_next;
    pcs_capture_pkg::capture_addr_t  write_addr;
    logic                            run_prev;
    logic                            run_edge;
    logic                            write_enable;
    logic                            last_addr;
    logic                            read_accept;
    logic [pcs_capture_pkg::LEN_KIND-1:0] kind_rd;

    // rising edge of the run level
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            run_prev <= 1'b0;
        else
            run_prev <= i_run;
    end

    assign run_edge = i_run & ~run_prev;

    // blocks in the edge cycle are dropped
    assign write_enable = (state == pcs_capture_pkg::ST_FILL) & i_dec_valid & ~run_edge;
    assign last_addr    = (write_addr == pcs_capture_pkg::capture_addr_t'(
                              pcs_capture_pkg::CAPTURE_DEPTH - 1));

    always_comb
    begin
        state_next = state;
        if (run_edge)
            state_next = pcs_capture_pkg::ST_FILL;    // restart from any state
        else if (write_enable && last_addr)
            state_next = pcs_capture_pkg::ST_FULL;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            state <= pcs_capture_pkg::ST_IDLE;
        else
            state <= state_next;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset || run_edge)
            write_addr <= '0;
        else if (write_enable)
            write_addr <= write_addr + pcs_capture_pkg::capture_addr_t'(1);    // wraps on full
    end

    assign o_full = (state == pcs_capture_pkg::ST_FULL);

    // reads only while the window is complete
    assign read_accept = i_read_strobe & o_full;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_read_valid <= 1'b0;
        else
            o_read_valid <= read_accept;
    end

    capture_bram
    #(
        .NB_WORD        (pcs_capture_pkg::LEN_CODED_BLOCK)
    )
    u_block_bram
    (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_data         (i_dec.block),
        .i_read_enable  (read_accept),
        .i_read_addr    (i_read_addr),
        .o_data         (o_read_block)
    );

    capture_bram
    #(
        .NB_WORD        (pcs_capture_pkg::LEN_KIND)
    )
    u_kind_bram
    (
        .i_clock        (i_clock),
        .i_write_enable (write_enable),
        .i_write_addr   (write_addr),
        .i_data         (i_dec.kind),
        .i_read_enable  (read_accept),
        .i_read_addr    (i_read_addr),
        .o_data         (kind_rd)
    );

    assign o_read_kind = pcs_capture_pkg::block_kind_e'(kind_rd);

endmodule

/* hdl/pcs_capture_top.sv */
`timescale 1ns/10ps

module pcs_capture_top
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_valid,
    input  pcs_capture_pkg::coded_block_t  i_block,
    input  logic                           i_run,
    input  logic                           i_read_strobe,
    input  pcs_capture_pkg::capture_addr_t i_read_addr,
    output logic                           o_full,
    output logic                           o_read_valid,
    output pcs_capture_pkg::coded_block_t  o_read_block,
    output pcs_capture_pkg::block_kind_e   o_read_kind
);

    logic                            dec_valid;
    pcs_capture_pkg::decoded_block_t dec;    // block plus kind, one cycle late

    block_kind_decoder u_decoder
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_block       (i_block),
        .o_valid       (dec_valid),
        .o_dec         (dec)
    );

    capture_control u_capture
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_run         (i_run),
        .i_dec_valid   (dec_valid),
        .i_dec         (dec),
        .i_read_strobe (i_read_strobe),
        .i_read_addr   (i_read_addr),
        .o_full        (o_full),
        .o_read_valid  (o_read_valid),
        .o_read_block  (o_read_block),
        .o_read_kind   (o_read_kind)
    );

endmodule

/* tb/capture_sva.sv */
`timescale 1ns/10ps

module capture_sva
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_run,
    input  logic                            i_write_enable,
    input  pcs_capture_pkg::capture_state_e i_state,
    input  logic                            i_full,
    input  logic                            i_read_valid
);

    // read data only follows a cycle with the window complete
    a_read_after_full: assert property (@(posedge i_clock) disable iff (i_reset)
        i_read_valid |-> $past(i_full))
    else $error("o_read_valid without o_full in the previous cycle");

    a_no_write_when_full: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_write_enable && i_state == pcs_capture_pkg::ST_FULL))
    else $error("memory write while the window is full");

    a_run_clears_full: assert property (@(posedge i_clock) disable iff (i_reset)
        $rose(i_run) |=> !i_full)
    else $error("o_full still high after a run edge");

endmodule

bind capture_control capture_sva u_sva
(
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_run          (i_run),
    .i_write_enable (write_enable),
    .i_state        (state),
    .i_full         (o_full),
    .i_read_valid   (o_read_valid)
);

/* tb/capture_checker.sv */
`timescale 1ns/10ps

module capture_checker
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic                           i_valid,
    input  pcs_capture_pkg::coded_block_t  i_block,
    input  logic                           i_run,
    input  logic                           i_read_strobe,
    input  pcs_capture_pkg::capture_addr_t i_read_addr,
    input  logic                           i_read_valid,
    input  pcs_capture_pkg::coded_block_t  i_read_block,
    input  pcs_capture_pkg::block_kind_e   i_read_kind
);

    int errors = 0;
    int reads_checked = 0;

    pcs_capture_pkg::coded_block_t  window [pcs_capture_pkg::CAPTURE_DEPTH];    // expected
    pcs_capture_pkg::coded_block_t  stage_block;    // block one cycle behind the port
    pcs_capture_pkg::capture_addr_t rd_addr;
    pcs_capture_pkg::block_kind_e   kind_exp;
    logic                           stage_valid;
    logic                           run_prev;
    logic                           run_edge;
    logic                           filling;
    logic                           full;
    logic                           accept;
    logic                           rv_exp;
    int                             count;

    always @(posedge i_clock)
    begin
        if (i_reset)
        begin
            stage_valid = 1'b0;
            run_prev    = 1'b0;
            filling     = 1'b0;
            full        = 1'b0;
            rv_exp      = 1'b0;
            count       = 0;
        end
        else
        begin
            if (i_read_valid !== rv_exp)
            begin
                errors++;
                if (rv_exp)
                    $display("no read data came back for the strobe at address %0d", rd_addr);
                else
                    $display("FAIL %0t: o_read_valid high with no accepted read strobe",
                             $time);
            end
            else if (rv_exp)
            begin
                reads_checked++;
                kind_exp = tb_pcs_capture.expected_kind(window[rd_addr]);
                if (i_read_block !== window[rd_addr])
                begin
                    errors++;
                    $display("FAIL %0t: address %0d block %h, expected %h",
                             $time, rd_addr, i_read_block, window[rd_addr]);
                end
                if (i_read_kind !== kind_exp)
                begin
                    errors++;
                    $display("FAIL %0t: address %0d kind %0d, expected %0d",
                             $time, rd_addr, i_read_kind, kind_exp);
                end
            end
            accept   = i_read_strobe & full;    // gated by the window state before this edge
            run_edge = i_run & ~run_prev;
            if (run_edge)
            begin
                filling = 1'b1;    // staged block is dropped
                full    = 1'b0;
                count   = 0;
            end
            else if (filling && stage_valid)
            begin
                window[count] = stage_block;
                count++;
                if (count == pcs_capture_pkg::CAPTURE_DEPTH)
                begin
                    filling = 1'b0;
                    full    = 1'b1;
                end
            end
            rv_exp      = accept;
            rd_addr     = i_read_addr;
            stage_valid = i_valid;
            stage_block = i_block;
            run_prev    = i_run;
        end
    end

endmodule

/* tb/tb_pcs_capture.sv */
`timescale 1ns/10ps

module tb_pcs_capture;

    localparam int WINDOW_CYCLES  = 40;
    localparam int NUM_WINDOWS    = 6;
    localparam int TIMEOUT_CYCLES = NUM_WINDOWS * WINDOW_CYCLES + 200;
    localparam int FULL_WAIT      = 8;     // polling bound for o_full
    localparam int DEPTH          = pcs_capture_pkg::CAPTURE_DEPTH;

    logic                           clock;
    logic                           reset;
    logic                           valid;
    pcs_capture_pkg::coded_block_t  block;
    logic                           run;
    logic                           read_strobe;
    pcs_capture_pkg::capture_addr_t read_addr;
    logic                           full;
    logic                           read_valid;
    pcs_capture_pkg::coded_block_t  read_block;
    pcs_capture_pkg::block_kind_e   read_kind;

    pcs_capture_pkg::coded_block_t  stim [DEPTH];
    pcs_capture_pkg::capture_addr_t order [DEPTH];
    logic [31:0]                    rng_state = 32'h62b52cea;
    int                             cycle_count = 0;
    int                             tb_errors = 0;
    int                             err_mark;
    int                             test_num = 0;
    int                             tests_failed = 0;
    string                          test_name;

    pcs_capture_top dut
    (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_valid       (valid),
        .i_block       (block),
        .i_run         (run),
        .i_read_strobe (read_strobe),
        .i_read_addr   (read_addr),
        .o_full        (full),
        .o_read_valid  (read_valid),
        .o_read_block  (read_block),
        .o_read_kind   (read_kind)
    );

    capture_checker u_checker
    (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_valid       (valid),
        .i_block       (block),
        .i_run         (run),
        .i_read_strobe (read_strobe),
        .i_read_addr   (read_addr),
        .i_read_valid  (read_valid),
        .i_read_block  (read_block),
        .i_read_kind   (read_kind)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // classification rules of the 64b/66b block-type table
    function automatic pcs_capture_pkg::block_kind_e expected_kind(
        input pcs_capture_pkg::coded_block_t blk
    );
        logic [1:0] sync;
        logic [7:0] bt;
        sync = blk[65:64];
        bt   = blk[63:56];
        if (sync == 2'b01)
            return pcs_capture_pkg::KIND_DATA;
        if (sync != 2'b10)
            return pcs_capture_pkg::KIND_ERROR;
        case (bt)
            8'h1e:                             return pcs_capture_pkg::KIND_IDLE;
            8'h78, 8'h33, 8'h66:               return pcs_capture_pkg::KIND_START;
            8'h4b:                             return pcs_capture_pkg::KIND_ORDERED;
            8'h87, 8'h99, 8'haa, 8'hb4,
            8'hcc, 8'hd2, 8'he1, 8'hff:        return pcs_capture_pkg::KIND_TERM;
            default:                           return pcs_capture_pkg::KIND_ERROR;
        endcase
    endfunction

    function automatic logic [7:0] listed_type(input int i);
        logic [7:0] types [13];
        types = '{8'h1e, 8'h78, 8'h33, 8'h66, 8'h4b, 8'h87, 8'h99,
                  8'haa, 8'hb4, 8'hcc, 8'hd2, 8'he1, 8'hff};
        return types[i % 13];
    endfunction

    // sync header followed by type byte and random payload
    function automatic pcs_capture_pkg::coded_block_t make_block(input logic [1:0] sync,
                                                                 input logic [7:0] bt);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_random();
        lo = next_random();
        if (sync == 2'b10)
            return {sync, bt, hi[23:0], lo};
        return {sync, hi, lo};
    endfunction

    function automatic int total_errors();
        return tb_errors + u_checker.errors;
    endfunction

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        err_mark  = total_errors();
    endtask

    task automatic end_test();
        if (total_errors() == err_mark)
            $display("test %0d %s: passed", test_num, test_name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed", test_num, test_name);
        end
    endtask

    task automatic start_window();
        @(negedge clock) run = 1'b0;
        @(negedge clock) run = 1'b1;    // rising edge opens the window
    endtask

    task automatic send_stim();
        for (int i = 0; i < DEPTH; i++)
        begin
            @(negedge clock);
            valid = 1'b1;
            block = stim[i];
        end
        @(negedge clock) valid = 1'b0;
    endtask

    task automatic wait_full();
        int n;
        for (n = 0; n < FULL_WAIT && !full; n++)
            @(negedge clock);
        if (!full)
        begin
            tb_errors++;
            $display("o_full did not rise within %0d cycles after the window was sent",
                     FULL_WAIT);
        end
    endtask

    task automatic shuffle_order(input logic random_order);
        int j;
        pcs_capture_pkg::capture_addr_t tmp;
        for (int i = 0; i < DEPTH; i++)
            order[i] = pcs_capture_pkg::capture_addr_t'(i);
        if (random_order)
        begin
            for (int i = DEPTH - 1; i > 0; i--)
            begin
                j = int'(next_random() % unsigned'(i + 1));
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
        end
    endtask

    // back-to-back strobes that the checker compares one by one
    task automatic read_window(input logic random_order);
        shuffle_order(random_order);
        for (int i = 0; i < DEPTH; i++)
        begin
            @(negedge clock);
            read_strobe = 1'b1;
            read_addr   = order[i];
        end
        @(negedge clock) read_strobe = 1'b0;
        @(negedge clock);
    endtask

    task automatic capture_and_read(input logic random_order);
        start_window();
        send_stim();
        wait_full();
        read_window(random_order);
    endtask

    initial
    begin
        reset       = 1'b1;
        valid       = 1'b0;
        block       = '0;
        run         = 1'b0;
        read_strobe = 1'b0;
        read_addr   = '0;
        repeat (5) @(posedge clock);
        @(negedge clock) reset = 1'b0;

        begin_test("reset state");
        @(negedge clock);
        if (full !== 1'b0 || read_valid !== 1'b0)
        begin
            tb_errors++;
            $display("FAIL %0t: o_full %b o_read_valid %b after reset", $time, full, read_valid);
        end
        @(negedge clock) read_strobe = 1'b1;    // ignored while no window exists
        read_addr = 5'd3;
        @(negedge clock) read_strobe = 1'b0;
        @(negedge clock);
        end_test();

        begin_test("data window");
        for (int i = 0; i < DEPTH; i++)
            stim[i] = make_block(2'b01, 8'h00);
        capture_and_read(1'b1);
        end_test();

        begin_test("control types");
        for (int i = 0; i < DEPTH; i++)
            stim[i] = make_block(2'b10, listed_type(i));
        capture_and_read(1'b0);
        end_test();

        begin_test("error blocks");
        for (int i = 0; i < DEPTH; i++)
        begin
            case (i % 4)
                0:       stim[i] = make_block(2'b00, 8'h00);
                1:       stim[i] = make_block(2'b11, 8'h00);
                default: stim[i] = make_block(2'b10, 8'(next_random() >> 24));
            endcase
            if (expected_kind(stim[i]) != pcs_capture_pkg::KIND_ERROR)
                stim[i][56] = ~stim[i][56];    // off the listed type table
        end
        capture_and_read(1'b1);
        end_test();

        begin_test("full window hold");
        for (int i = 0; i < DEPTH; i++)
            stim[i] = make_block(2'b10, listed_type(int'(next_random() % 32'd13)));
        start_window();
        send_stim();
        wait_full();
        for (int i = 0; i < 4; i++)
            stim[i] = make_block(2'b01, 8'h00);
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clock);
            valid = 1'b1;
            block = stim[i];
        end
        @(negedge clock) valid = 1'b0;
        @(negedge clock);
        read_window(1'b0);
        start_window();
        @(negedge clock) read_strobe = 1'b1;
        read_addr = 5'd0;
        @(negedge clock) read_strobe = 1'b0;
        if (full)
        begin
            tb_errors++;
            $display("FAIL %0t: o_full stayed high after a new run edge", $time);
        end
        @(negedge clock);
        end_test();

        begin_test("second window");
        for (int i = 0; i < DEPTH; i++)
            stim[i] = next_random() & 1 ? make_block(2'b01, 8'h00)
                                        : make_block(2'b10, listed_type(i + 3));
        capture_and_read(1'b1);
        end_test();

        $display("%0d tests, %0d failed, %0d errors, %0d reads checked",
                 test_num, tests_failed, total_errors(), u_checker.reads_checked);
        if (tests_failed == 0 && total_errors() == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* build.f */
hdl/pcs_capture_pkg.sv
hdl/block_kind_decoder.sv
hdl/capture_bram.sv
hdl/capture_control.sv
hdl/pcs_capture_top.sv
tb/capture_sva.sv
tb/capture_checker.sv
tb/tb_pcs_capture.sv

/* Makefile */
TOP := tb_pcs_capture

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
